// ==== logic/fe_rx_consts.svh ====
// front-end receiver constants
// sync pattern, channel count, FIFO depths and per-channel register offsets
`ifndef FE_RX_CONSTS_SVH
`define FE_RX_CONSTS_SVH

// alignment symbol, prefix 00 so it never looks like data
`define RX_SYNC_SYMBOL      10'b0011111010

`define RX_CHANNELS         2
`define RX_CH_FIFO_DEPTH    8   // words per channel
`define RX_OUT_FIFO_DEPTH   8   // words in shared output FIFO

// register offsets inside a 16-address channel window
`define RX_REG_SOFT_RST     4'd0
`define RX_REG_CONF         4'd1
`define RX_REG_SIZE_LO      4'd2
`define RX_REG_SIZE_HI      4'd3
`define RX_REG_DEC_ERR      4'd4
`define RX_REG_LOST_ERR     4'd5

`endif

// ==== logic/fe_rx_pkg.sv ====
// front-end receiver types
// hit word from one channel and the headered word of the output FIFO
`default_nettype none

package fe_rx_pkg;

    // three decoded bytes, first received byte on top
    typedef logic [23:0] fe_word_t;

    // channel header over the hit word, 32 bits in total
    typedef struct packed {
        logic [7:0] header;   // channel number
        fe_word_t   data;
    } out_word_t;

endpackage

`default_nettype wire

// ==== logic/rx_word_fifo.sv ====
// word FIFO with show-ahead output
// payload type set by parameter, pushes ignored while full, 16-bit fill count
`timescale 1ns/1ps
`default_nettype none

module rx_word_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  wire        BUS_CLK,
    input  wire        RST,
    input  wire        push,
    input  payload_t   push_data,
    input  wire        pop,
    output payload_t   pop_data,
    output logic       empty,
    output logic       full,
    output logic [15:0] count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            do_push;
    logic            do_pop;

    assign empty    = (count == 16'd0);
    assign full     = (count == 16'(DEPTH));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];   // head word visible while not empty

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 16'd0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 16'd1;
            else if (do_pop && !do_push)
                count <= count - 16'd1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // the reader must check empty before popping
    a_no_pop_when_empty: assert property (@(posedge BUS_CLK) disable iff (RST) pop |-> !empty);

endmodule

`default_nettype wire

// ==== logic/rx_frame_sync.sv ====
// serial frame sync for one receiver channel
// aligns on the sync symbol, decodes 10-bit symbols and packs three bytes per word
`timescale 1ns/1ps
`default_nettype none
`include "fe_rx_consts.svh"

module rx_frame_sync (
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire                   rx_data,
    input  wire                   invert,
    output logic                  ready,
    output logic                  word_valid,
    output fe_rx_pkg::fe_word_t   word,
    output logic                  decode_err
);

    logic        bit_in;
    logic [9:0]  win;        // last ten line bits
    logic [9:0]  win_next;
    logic [3:0]  bit_cnt;    // position inside the symbol
    logic [1:0]  byte_cnt;   // bytes collected for the current word
    logic [15:0] acc;
    logic        sym_done;
    logic        is_sync;
    logic        is_data;

    assign bit_in   = rx_data ^ invert;
    assign win_next = {win[8:0], bit_in};
    assign sym_done = ready && (bit_cnt == 4'd9);
    assign is_sync  = (win_next == `RX_SYNC_SYMBOL);
    assign is_data  = (win_next[9:8] == 2'b01);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            win        <= 10'd0;
            ready      <= 1'b0;
            bit_cnt    <= 4'd0;
            byte_cnt   <= 2'd0;
            word_valid <= 1'b0;
            decode_err <= 1'b0;
        end else begin
            win        <= win_next;
            word_valid <= 1'b0;
            decode_err <= 1'b0;
            if (!ready) begin
                if (is_sync) begin   // symbol boundary found
                    ready    <= 1'b1;
                    bit_cnt  <= 4'd0;
                    byte_cnt <= 2'd0;
                end
            end else if (sym_done) begin
                bit_cnt <= 4'd0;
                if (is_sync) begin
                    byte_cnt <= 2'd0;   // restart assembly
                end else if (is_data) begin
                    if (byte_cnt == 2'd2) begin
                        word_valid <= 1'b1;
                        byte_cnt   <= 2'd0;
                    end else begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end else begin
                    decode_err <= 1'b1;   // drop partial word
                    byte_cnt   <= 2'd0;
                end
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // byte payload, qualified by word_valid
    always_ff @(posedge BUS_CLK) begin
        if (sym_done && is_data) begin
            acc <= {acc[7:0], win_next[7:0]};
            if (byte_cnt == 2'd2)
                word <= {acc, win_next[7:0]};
        end
    end

    // once locked, only a clear may drop the lock
    a_ready_holds: assert property (@(posedge BUS_CLK) (ready && !RST) |=> ready);

endmodule

`default_nettype wire

// ==== logic/fe_rx_channel.sv ====
// one receiver channel
// host registers, error counters, frame sync and the channel word FIFO
`timescale 1ns/1ps
`default_nettype none
`include "fe_rx_consts.svh"

module fe_rx_channel #(
    parameter int CHANNEL_ID = 0
) (
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire  [7:0]            bus_add,
    input  wire  [7:0]            bus_data_in,
    input  wire                   bus_wr,
    input  wire                   bus_rd,
    input  wire                   rx_data,
    input  wire  [7:0]            rd_chain_in,
    output logic [7:0]            rd_chain_out,
    output logic                  ready,
    input  wire                   ch_pop,
    output logic                  ch_empty,
    output fe_rx_pkg::fe_word_t   ch_data
);

    logic                in_window;
    logic [3:0]          offset;
    logic                soft_rst;
    logic                clr;           // RST or soft reset write
    logic [7:0]          conf;
    logic [7:0]          dec_err_cnt;
    logic [7:0]          lost_cnt;
    logic [7:0]          reg_val;
    logic [7:0]          rd_q;
    logic                rd_sel;        // last read hit this window
    logic                word_valid;
    logic                decode_err;
    logic                fifo_full;
    logic [15:0]         fifo_count;
    fe_rx_pkg::fe_word_t word;

    assign in_window = (bus_add[7:4] == 4'(CHANNEL_ID));
    assign offset    = bus_add[3:0];
    assign soft_rst  = bus_wr && in_window && (offset == `RX_REG_SOFT_RST);
    assign clr       = RST || soft_rst;

    always_ff @(posedge BUS_CLK) begin
        if (clr)
            conf <= 8'd0;
        else if (bus_wr && in_window && offset == `RX_REG_CONF)
            conf <= bus_data_in;
    end

    // saturating counters
    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            dec_err_cnt <= 8'd0;
            lost_cnt    <= 8'd0;
        end else begin
            if (decode_err && dec_err_cnt != 8'hff)
                dec_err_cnt <= dec_err_cnt + 8'd1;
            if (word_valid && fifo_full && lost_cnt != 8'hff)
                lost_cnt <= lost_cnt + 8'd1;
        end
    end

    always_comb begin
        case (offset)
            `RX_REG_CONF:     reg_val = {conf[7:1], ready};   // bit 0 reads back ready
            `RX_REG_SIZE_LO:  reg_val = fifo_count[7:0];
            `RX_REG_SIZE_HI:  reg_val = fifo_count[15:8];
            `RX_REG_DEC_ERR:  reg_val = dec_err_cnt;
            `RX_REG_LOST_ERR: reg_val = lost_cnt;
            default:          reg_val = 8'd0;
        endcase
    end

    // read chain, value captured on bus_rd and held until the next read
    always_ff @(posedge BUS_CLK) begin
        if (RST)
            rd_sel <= 1'b0;
        else if (bus_rd)
            rd_sel <= in_window;
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd && in_window)
            rd_q <= reg_val;
    end

    assign rd_chain_out = rd_sel ? rd_q : rd_chain_in;

    rx_frame_sync u_sync (
        .BUS_CLK    (BUS_CLK),
        .RST        (clr),
        .rx_data    (rx_data),
        .invert     (conf[1]),
        .ready      (ready),
        .word_valid (word_valid),
        .word       (word),
        .decode_err (decode_err)
    );

    rx_word_fifo #(
        .payload_t (fe_rx_pkg::fe_word_t),
        .DEPTH     (`RX_CH_FIFO_DEPTH)
    ) u_fifo (
        .BUS_CLK   (BUS_CLK),
        .RST       (clr),
        .push      (word_valid),   // dropped by the FIFO when full
        .push_data (word),
        .pop       (ch_pop),
        .pop_data  (ch_data),
        .empty     (ch_empty),
        .full      (fifo_full),
        .count     (fifo_count)
    );

    // words are only counted as lost against a full FIFO
    a_lost_only_when_full: assert property (@(posedge BUS_CLK)
        (!clr && !fifo_full) |=> $stable(lost_cnt));

endmodule

`default_nettype wire

// ==== logic/readout_arbiter.sv ====
// round-robin readout arbiter
// moves channel words into the output FIFO with the channel number as header
`timescale 1ns/1ps
`default_nettype none

module readout_arbiter (
    input  wire                    BUS_CLK,
    input  wire                    RST,
    input  wire  [1:0]             ch_empty,
    input  fe_rx_pkg::fe_word_t    ch_data0,
    input  fe_rx_pkg::fe_word_t    ch_data1,
    output logic [1:0]             ch_pop,
    input  wire                    out_full,
    output logic                   out_push,
    output fe_rx_pkg::out_word_t   out_data
);

    logic                last_q;      // channel served last
    logic                gnt;
    logic                gnt_valid;
    logic                can_pop;
    fe_rx_pkg::fe_word_t gnt_data;

    // one word in flight at most, so out_full is never overrun
    assign can_pop = !out_full && !out_push;

    always_comb begin
        gnt       = ~last_q;
        gnt_valid = 1'b0;
        if (!ch_empty[~last_q]) begin   // other channel first
            gnt       = ~last_q;
            gnt_valid = 1'b1;
        end else if (!ch_empty[last_q]) begin
            gnt       = last_q;
            gnt_valid = 1'b1;
        end
    end

    assign ch_pop   = (gnt_valid && can_pop) ? (2'b01 << gnt) : 2'b00;
    assign gnt_data = gnt ? ch_data1 : ch_data0;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            last_q   <= 1'b1;   // channel 0 goes first
            out_push <= 1'b0;
        end else begin
            out_push <= |ch_pop;
            if (|ch_pop)
                last_q <= gnt;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (|ch_pop)
            out_data <= '{header: 8'(gnt), data: gnt_data};
    end

    a_pop_onehot0: assert property (@(posedge BUS_CLK) disable iff (RST) $onehot0(ch_pop));

endmodule

`default_nettype wire

// ==== logic/fe_rx_top.sv ====
// front-end readout top level
// two serial channels merged by the arbiter into one output FIFO
`timescale 1ns/1ps
`default_nettype none
`include "fe_rx_consts.svh"

module fe_rx_top (
    input  wire                        BUS_CLK,
    input  wire                        RST,
    input  wire  [7:0]                 bus_add,
    input  wire  [7:0]                 bus_data_in,
    input  wire                        bus_wr,
    input  wire                        bus_rd,
    output logic [7:0]                 bus_data_out,
    input  wire  [`RX_CHANNELS-1:0]    rx_data,
    output logic [`RX_CHANNELS-1:0]    rx_ready,
    input  wire                        fifo_read,
    output logic                       fifo_empty,
    output logic [31:0]                fifo_data
);

    logic [7:0]            rd_chain [`RX_CHANNELS+1];   // read data chain
    logic [`RX_CHANNELS-1:0] ch_empty;
    logic [`RX_CHANNELS-1:0] ch_pop;
    fe_rx_pkg::fe_word_t   ch_data [`RX_CHANNELS];
    logic                  out_push;
    logic                  out_full;
    fe_rx_pkg::out_word_t  out_data;

    assign rd_chain[0]  = 8'h00;
    assign bus_data_out = rd_chain[`RX_CHANNELS];

    for (genvar i = 0; i < `RX_CHANNELS; i++) begin : g_ch
        fe_rx_channel #(
            .CHANNEL_ID (i)
        ) u_ch (
            .BUS_CLK      (BUS_CLK),
            .RST          (RST),
            .bus_add      (bus_add),
            .bus_data_in  (bus_data_in),
            .bus_wr       (bus_wr),
            .bus_rd       (bus_rd),
            .rx_data      (rx_data[i]),
            .rd_chain_in  (rd_chain[i]),
            .rd_chain_out (rd_chain[i+1]),
            .ready        (rx_ready[i]),
            .ch_pop       (ch_pop[i]),
            .ch_empty     (ch_empty[i]),
            .ch_data      (ch_data[i])
        );
    end

    readout_arbiter u_arb (
        .BUS_CLK  (BUS_CLK),
        .RST      (RST),
        .ch_empty (ch_empty),
        .ch_data0 (ch_data[0]),
        .ch_data1 (ch_data[1]),
        .ch_pop   (ch_pop),
        .out_full (out_full),
        .out_push (out_push),
        .out_data (out_data)
    );

    rx_word_fifo #(
        .payload_t (fe_rx_pkg::out_word_t),
        .DEPTH     (`RX_OUT_FIFO_DEPTH)
    ) u_out_fifo (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .push      (out_push),
        .push_data (out_data),
        .pop       (fifo_read),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (out_full),
        .count     ()
    );

endmodule

`default_nettype wire

// ==== tb/tb_fe_rx.sv ====
// testbench for the front-end readout top level
// serial line driver, host bus tasks, reference packer and output scoreboard
`timescale 1ns/1ps
`default_nettype none
`include "fe_rx_consts.svh"

module tb_fe_rx;

    logic        BUS_CLK;
    logic        RST;
    logic [7:0]  bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    wire  [7:0]  bus_data_out;
    logic [1:0]  rx_data = 2'b00;
    wire  [1:0]  rx_ready;
    logic        fifo_read = 1'b0;
    wire         fifo_empty;
    wire  [31:0] fifo_data;

    integer      seed = 32'h4ebe1335;
    integer      errors = 0;
    integer      checks = 0;
    logic [1:0]  mute;        // line held low while set
    logic [1:0]  inv;         // line driven inverted
    logic        drain_en;    // host reads the output FIFO
    bit          line_q0 [$];
    bit          line_q1 [$];
    logic [31:0] exp_q0 [$];  // expected words per channel
    logic [31:0] exp_q1 [$];

    fe_rx_top UUT (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .rx_data      (rx_data),
        .rx_ready     (rx_ready),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #10 BUS_CLK = ~BUS_CLK;
    end

    // channel header on top, first received byte next
    function automatic logic [31:0] expected_word(input int ch, input logic [7:0] b0,
                                                  input logic [7:0] b1, input logic [7:0] b2);
        return {8'(ch), b0, b1, b2};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // queue one 10-bit symbol on a line, msb first
    task automatic push_symbol(input int ch, input logic [9:0] sym);
        logic [9:0] s;
        int         k;
        s = sym ^ {10{inv[ch]}};
        for (k = 9; k >= 0; k--) begin
            if (ch == 0)
                line_q0.push_back(s[k]);
            else
                line_q1.push_back(s[k]);
        end
    endtask

    task automatic send_byte(input int ch, input logic [7:0] b);
        push_symbol(ch, {2'b01, b});   // data prefix
    endtask

    task automatic send_word(input int ch, input bit keep);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        b0 = 8'($random(seed));
        b1 = 8'($random(seed));
        b2 = 8'($random(seed));
        if (keep && ch == 0)
            exp_q0.push_back(expected_word(ch, b0, b1, b2));
        else if (keep)
            exp_q1.push_back(expected_word(ch, b0, b1, b2));
        send_byte(ch, b0);
        send_byte(ch, b1);
        send_byte(ch, b2);
    endtask

    // only called while idle or muted, so symbol alignment is kept
    task automatic set_line(input int ch, input bit hold, input bit invert);
        @(posedge BUS_CLK);
        mute[ch] = hold;
        inv[ch]  = invert;
        if (ch == 0)
            line_q0.delete();
        else
            line_q1.delete();
    endtask

    // idle lines carry sync symbols
    always @(posedge BUS_CLK) begin
        if (line_q0.size() == 0)
            push_symbol(0, `RX_SYNC_SYMBOL);
        if (line_q1.size() == 0)
            push_symbol(1, `RX_SYNC_SYMBOL);
        if (mute[0])
            rx_data[0] <= 1'b0;
        else
            rx_data[0] <= line_q0.pop_front();
        if (mute[1])
            rx_data[1] <= 1'b0;
        else
            rx_data[1] <= line_q1.pop_front();
    end

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr      <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(posedge BUS_CLK);   // data held from one cycle after the strobe
        data = bus_data_out;
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [7:0] exp, input string name);
        logic [7:0] val;
        bus_read(addr, val);
        check(name, 32'(val), 32'(exp));
    endtask

    task automatic poll_reg(input logic [7:0] addr, input logic [7:0] exp);
        logic [7:0] val;
        int         n;
        n = 0;
        bus_read(addr, val);
        while (val != exp && n < 400) begin
            bus_read(addr, val);
            n++;
        end
        if (val != exp) begin
            errors++;
            $display("register 0x%h never reached its expected value", addr);
        end
    endtask

    task automatic wait_ready(input int ch);
        int n;
        n = 0;
        while (!rx_ready[ch] && n < 200) begin
            @(posedge BUS_CLK);
            n++;
        end
        if (!rx_ready[ch]) begin
            errors++;
            $display("channel %0d did not lock to the sync symbol", ch);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < 5000) begin
            @(posedge BUS_CLK);
            n++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            errors++;
            $display("expected words never came out of the output FIFO");
        end
    endtask

    // scoreboard, one pop every other cycle at most
    always @(posedge BUS_CLK) begin
        if (fifo_read) begin
            if (fifo_data[31:24] == 8'd0 && exp_q0.size() != 0)
                check("fifo_data", fifo_data, exp_q0.pop_front());
            else if (fifo_data[31:24] == 8'd1 && exp_q1.size() != 0)
                check("fifo_data", fifo_data, exp_q1.pop_front());
            else begin
                errors++;
                $display("unexpected word 0x%h read from the output FIFO", fifo_data);
            end
        end
        fifo_read <= drain_en && !fifo_empty && !fifo_read;
    end

    initial begin
        RST         = 1'b1;
        bus_add     = 8'h00;
        bus_data_in = 8'h00;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        mute        = 2'b11;
        inv         = 2'b00;
        drain_en    = 1'b0;
        repeat (2) @(posedge BUS_CLK);
        RST <= 1'b0;
        @(posedge BUS_CLK);
        check("fifo_empty", 32'(fifo_empty), 32'h1);
        check("bus_data_out", 32'(bus_data_out), 32'h0);

        // configuration readback, ready low before sync
        bus_write(8'h01, 8'ha5);
        bus_write(8'h11, 8'h58);
        check_reg(8'h01, 8'ha4, "ch0 conf");
        check_reg(8'h11, 8'h58, "ch1 conf");
        set_line(0, 1'b0, 1'b0);
        set_line(1, 1'b0, 1'b0);
        wait_ready(0);
        wait_ready(1);
        check_reg(8'h01, 8'ha5, "ch0 conf");
        check_reg(8'h11, 8'h59, "ch1 conf");

        // interleaved traffic on both lines
        drain_en = 1'b1;
        repeat (6) begin
            send_word(0, 1'b1);
            send_word(1, 1'b1);
        end
        wait_drained();

        // bad prefixes on channel 1, partial words lost
        send_word(1, 1'b1);
        send_byte(1, 8'h5a);
        push_symbol(1, {2'b10, 8'h3c});
        send_word(1, 1'b1);
        push_symbol(1, {2'b11, 8'h81});
        send_word(1, 1'b1);
        wait_drained();
        check_reg(8'h14, 8'h02, "ch1 dec_err");
        check_reg(8'h04, 8'h00, "ch0 dec_err");

        // overflow, 16 words fit in channel and output FIFOs
        drain_en = 1'b0;
        for (int i = 0; i < 20; i++)
            send_word(0, i < 16);
        poll_reg(8'h05, 8'h04);
        check_reg(8'h05, 8'h04, "ch0 lost");
        check_reg(8'h02, 8'h08, "ch0 fill");
        drain_en = 1'b1;
        wait_drained();
        check_reg(8'h02, 8'h00, "ch0 fill");
        check("fifo_empty", 32'(fifo_empty), 32'h1);

        // soft reset of channel 1 only, with words waiting in its FIFO
        drain_en = 1'b0;
        for (int i = 0; i < 10; i++)
            send_word(0, 1'b1);
        poll_reg(8'h02, 8'h02);   // output FIFO full, two words held in channel 0
        send_word(1, 1'b0);
        send_word(1, 1'b0);
        poll_reg(8'h12, 8'h02);
        set_line(1, 1'b1, 1'b0);
        bus_write(8'h10, 8'h00);
        check_reg(8'h11, 8'h00, "ch1 conf");
        check_reg(8'h14, 8'h00, "ch1 dec_err");
        check_reg(8'h12, 8'h00, "ch1 fill");
        check_reg(8'h01, 8'ha5, "ch0 conf");
        check_reg(8'h05, 8'h04, "ch0 lost");
        check_reg(8'h02, 8'h02, "ch0 fill");
        check("rx_ready", 32'(rx_ready), 32'h1);
        drain_en = 1'b1;
        wait_drained();

        // inverted line on channel 1
        bus_write(8'h11, 8'h02);
        set_line(1, 1'b0, 1'b1);
        wait_ready(1);
        check_reg(8'h11, 8'h03, "ch1 conf");
        repeat (6) begin
            send_word(0, 1'b1);
            send_word(1, 1'b1);
        end
        wait_drained();
        check_reg(8'h14, 8'h00, "ch1 dec_err");

        repeat (5) @(posedge BUS_CLK);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/fe_rx_pkg.sv
logic/rx_word_fifo.sv
logic/rx_frame_sync.sv
logic/fe_rx_channel.sv
logic/readout_arbiter.sv
logic/fe_rx_top.sv
tb/tb_fe_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fe_rx -f tb.f \
    && ./obj_dir/Vtb_fe_rx > sim.log 2>&1 \
    && cat sim.log \
    && grep -q 'All tests passed!' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
